// File: vlog.f
hdl/filter_pkg.sv
hdl/filter_config_regs.sv
hdl/filter_cond_kernel.sv
hdl/filter_stream_stage.sv
hdl/filter_engine_top.sv
dv/filter_engine_tb.sv

// File: Bender.yml
package:
  name: filter_engine

sources:
  - files:
      - hdl/filter_pkg.sv
      - hdl/filter_config_regs.sv
      - hdl/filter_cond_kernel.sv
      - hdl/filter_stream_stage.sv
      - hdl/filter_engine_top.sv
  - target: test
    files:
      - dv/filter_engine_tb.sv

// File: dv/filter_engine_tb.sv
/*
 * Filter engine testbench
 * Random packets checked against a model of the filter rules, with
 * AXI4-Lite configuration, register readback and counter checks.
 */

`timescale 1ns/1ns

module filter_engine_tb import filter_pkg::*; ();

  localparam int NF          = 4;
  localparam int DW          = NF * FIELD_W;
  localparam int SW          = NF * STATE_W;
  localparam int PKTS        = 200;
  localparam int RUNS        = 14;
  localparam int AXI_CYC_RUN = 60;
  localparam int SETUP_CYC   = 300;
  localparam int TIMEOUT_CYC = 2 * (RUNS * (PKTS + AXI_CYC_RUN) + SETUP_CYC);
  localparam logic [31:0] NF_MASK = (32'd1 << NF) - 32'd1;

  logic                  ap_clk;
  logic                  rst_n;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic [3:0]            wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  in_valid;
  logic [DW-1:0]         in_data;
  logic [SW-1:0]         in_state;
  logic                  out_valid;
  logic [DW-1:0]         out_data;
  logic [SW-1:0]         out_state;

  // Model copy of the configuration
  logic [3:0]            cfg_op;
  logic                  cfg_eq;
  logic                  cfg_keep;
  logic [NF-1:0]         cfg_fmask;
  logic [NF-1:0]         cfg_cmask;
  logic [31:0]           cfg_cval;
  logic [NF-1:0]         cfg_ops [NF];

  // Expected outputs keyed by their due cycle
  int                    exp_cyc   [$];
  bit                    exp_pass  [$];
  logic [DW-1:0]         exp_data  [$];
  logic [SW-1:0]         exp_state [$];

  int                    cyc = 0;
  int                    errs = 0;
  int                    checks = 0;
  int                    pass_cnt = 0;
  int                    drop_cnt = 0;
  logic [31:0]           rng;

  filter_engine_top #(
    .NUM_FIELDS (NF)
  ) filter_engine_top_i (
    .ap_clk (ap_clk), .rst_n (rst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .in_valid (in_valid), .in_data (in_data), .in_state (in_state),
    .out_valid (out_valid), .out_data (out_data), .out_state (out_state)
  );

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cyc <= cyc + 1;
    if (cyc > TIMEOUT_CYC) begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYC);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic check_value(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED %s at cycle %0d: got %0h expected %0h", name, cyc, got, exp);
    end
  endtask

  // --------------------
  // AXI4-Lite access
  // --------------------
  task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge ap_clk);
    while (!(awready && wready)) @(negedge ap_clk);
    @(posedge ap_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge ap_clk);
    while (!bvalid) @(negedge ap_clk);
    check_value("bresp", bresp, 2'b00);
    @(posedge ap_clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge ap_clk);
    while (!arready) @(negedge ap_clk);
    @(posedge ap_clk);
    #1;
    arvalid = 1'b0;
    @(negedge ap_clk);
    while (!rvalid) @(negedge ap_clk);
    data = rdata;
    check_value("rresp", rresp, 2'b00);
    @(posedge ap_clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic expect_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    read_reg(addr, got);
    check_value($sformatf("rdata@%02h", addr), got, exp);
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic bit cond_holds(input logic [3:0] op, input logic [31:0] a,
                                    input logic [31:0] b);
    bit same;
    same = (a == b);
    case (op)
      FILTER_GT, FILTER_GT_TERN:         return (a > b) || (cfg_eq && same);
      FILTER_LT, FILTER_LT_TERN:         return (a < b) || (cfg_eq && same);
      FILTER_EQ, FILTER_EQ_TERN:         return same;
      FILTER_NOT_EQ, FILTER_NOT_EQ_TERN: return !same;
      default:                           return 1'b1;
    endcase
  endfunction

  task automatic model_packet(input logic [DW-1:0] d, input logic [SW-1:0] s,
                              output logic [DW-1:0] od, output logic [SW-1:0] os,
                              output bit pass);
    logic [31:0] opv [NF];
    logic [1:0]  opst [NF];
    logic [31:0] org [NF];
    logic [1:0]  orgst [NF];
    logic [31:0] outv [NF];
    logic [31:0] rv;
    logic [1:0]  rs;
    bit          found;
    bit          hold;
    pass = 1'b1;
    for (int i = 0; i < NF; i++) begin
      rv    = '0;
      rs    = FIELD_INVALID;
      found = 1'b0;
      // Highest set bit of the ops mask selects the source field
      for (int j = NF - 1; j >= 0; j--) begin
        if (!found && cfg_ops[i][j]) begin
          rv    = d[j*FIELD_W +: FIELD_W];
          rs    = s[j*STATE_W +: STATE_W];
          found = 1'b1;
        end
      end
      opv[i]   = cfg_cmask[i] ? cfg_cval : rv;
      opst[i]  = cfg_cmask[i] ? FIELD_RUNNING : rs;
      org[i]   = (cfg_cmask[i] && cfg_keep) ? cfg_cval : rv;
      orgst[i] = (cfg_cmask[i] && cfg_keep) ? FIELD_RUNNING : rs;
      outv[i]  = org[i];
    end
    hold = cond_holds(cfg_op, opv[0], opv[1]);
    case (cfg_op)
      FILTER_NOP: begin
        outv  = opv;
        orgst = opst;
      end
      FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NOT_EQ: begin
        for (int i = 0; i < NF; i++) begin
          if (cfg_fmask[i] && !cond_holds(cfg_op, opv[i], opv[(i + 1) % NF])) pass = 1'b0;
        end
      end
      FILTER_GT_TERN, FILTER_LT_TERN: begin
        outv = opv;
        if (!hold) begin
          outv[0] = opv[1];
          outv[1] = opv[0];
        end
      end
      FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        outv = opv;
        if (hold) begin
          outv[0]    = opv[NF-1];
          outv[NF-1] = opv[0];
        end
      end
      default: ;
    endcase
    for (int i = 0; i < NF; i++) begin
      od[i*FIELD_W +: FIELD_W] = outv[i];
      os[i*STATE_W +: STATE_W] = orgst[i];
    end
  endtask

  // Compare against the output due this cycle
  always @(negedge ap_clk) begin : monitor
    bit            p;
    logic [DW-1:0] d;
    logic [SW-1:0] s;
    if (rst_n) begin
      if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
        void'(exp_cyc.pop_front());
        p = exp_pass.pop_front();
        d = exp_data.pop_front();
        s = exp_state.pop_front();
        check_value("out_valid", out_valid, p);
        if (p) begin
          check_value("out_data", out_data, d);
          check_value("out_state", out_state, s);
        end
      end else begin
        check_value("out_valid", out_valid, 1'b0);
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic send_packets(input int count, input bit near_equal);
    logic [DW-1:0] d;
    logic [SW-1:0] s;
    logic [DW-1:0] od;
    logic [SW-1:0] os;
    bit            p;
    bit            v;
    for (int n = 0; n < count; n++) begin
      v = (next_rand() % 4) != 0;
      for (int f = 0; f < NF; f++) begin
        d[f*FIELD_W +: FIELD_W] = near_equal ? next_rand() % 4 : next_rand();
        s[f*STATE_W +: STATE_W] = STATE_W'(next_rand() % 3);
      end
      in_valid = v;
      in_data  = d;
      in_state = s;
      if (v) begin
        model_packet(d, s, od, os, p);
        exp_cyc.push_back(cyc + 3);
        exp_pass.push_back(p);
        exp_data.push_back(od);
        exp_state.push_back(os);
        if (p) pass_cnt++;
        else   drop_cnt++;
      end
      @(posedge ap_clk);
      #1;
    end
    in_valid = 1'b0;
    // Pipeline drains in three cycles
    repeat (4) @(posedge ap_clk);
    #1;
  endtask

  task automatic load_config();
    write_reg(REG_CTRL, {26'd0, cfg_keep, cfg_eq, cfg_op}, 4'hf);
    write_reg(REG_FILTER_MASK, 32'(cfg_fmask), 4'hf);
    write_reg(REG_CONST_MASK, 32'(cfg_cmask), 4'hf);
    write_reg(REG_CONST_VALUE, cfg_cval, 4'hf);
    for (int i = 0; i < NF; i++) begin
      write_reg(AXI_ADDR_W'(REG_OPS_BASE + 4 * i), 32'(cfg_ops[i]), 4'hf);
    end
  endtask

  task automatic check_counters();
    expect_reg(REG_PASS_COUNT, pass_cnt);
    expect_reg(REG_DROP_COUNT, drop_cnt);
  endtask

  task automatic run_phase(input logic [3:0] op, input logic keep, input bit near_equal);
    logic [31:0] r;
    r         = next_rand();
    cfg_op    = op;
    cfg_keep  = keep;
    cfg_eq    = r[0];
    cfg_fmask = r[8 +: NF];
    cfg_cmask = r[16 +: NF] & r[24 +: NF];
    if (cfg_cmask == '0) cfg_cmask[0] = 1'b1;
    cfg_cval  = near_equal ? next_rand() % 4 : next_rand();
    for (int i = 0; i < NF; i++) cfg_ops[i] = NF'(next_rand());
    load_config();
    send_packets(PKTS, near_equal);
    check_counters();
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    rng      = 32'hdc3a;
    rst_n    = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    in_state = '0;
    repeat (10) @(posedge ap_clk);
    #1;
    rst_n = 1'b1;
    @(posedge ap_clk);
    #1;

    // Handshake outputs idle after reset
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("arready", arready, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);

    // Every address reads zero after reset
    for (int a = 0; a < 64; a += 4) expect_reg(AXI_ADDR_W'(a), 32'd0);
    r = next_rand();
    write_reg(REG_CTRL, r, 4'hf);
    expect_reg(REG_CTRL, r & 32'h3f);
    r = next_rand();
    write_reg(REG_FILTER_MASK, r, 4'hf);
    expect_reg(REG_FILTER_MASK, r & NF_MASK);
    r = next_rand();
    write_reg(REG_CONST_MASK, r, 4'hf);
    expect_reg(REG_CONST_MASK, r & NF_MASK);
    r = next_rand();
    write_reg(REG_CONST_VALUE, r, 4'hf);
    w = next_rand();
    write_reg(REG_CONST_VALUE, w, 4'b0101);
    expect_reg(REG_CONST_VALUE, {r[31:24], w[23:16], r[15:8], w[7:0]});
    for (int i = 0; i < NF; i++) begin
      r = next_rand();
      write_reg(AXI_ADDR_W'(REG_OPS_BASE + 4 * i), r, 4'hf);
      expect_reg(AXI_ADDR_W'(REG_OPS_BASE + 4 * i), r & NF_MASK);
    end
    write_reg(6'h18, next_rand(), 4'hf);
    expect_reg(6'h18, 32'd0);
    write_reg(6'h3c, next_rand(), 4'hf);
    expect_reg(6'h3c, 32'd0);

    run_phase(FILTER_NOP, 1'b0, 1'b0);
    run_phase(FILTER_GT, 1'b0, 1'b1);
    run_phase(FILTER_LT, 1'b0, 1'b1);
    run_phase(FILTER_EQ, 1'b0, 1'b1);
    run_phase(FILTER_NOT_EQ, 1'b0, 1'b1);
    run_phase(FILTER_GT_TERN, 1'b0, 1'b1);
    run_phase(FILTER_LT_TERN, 1'b0, 1'b1);
    run_phase(FILTER_EQ_TERN, 1'b0, 1'b1);
    run_phase(FILTER_NOT_EQ_TERN, 1'b0, 1'b1);

    // Constant keep toggled over an otherwise unchanged configuration
    run_phase(FILTER_GT, 1'b0, 1'b1);
    cfg_keep = 1'b1;
    load_config();
    send_packets(PKTS, 1'b1);
    check_counters();
    cfg_op = FILTER_NOP;
    load_config();
    send_packets(PKTS, 1'b1);
    check_counters();

    run_phase(4'd9, 1'b1, 1'b0);
    run_phase(4'd15, 1'b0, 1'b0);

    $display("Checks: %0d, errors: %0d, passed packets: %0d, dropped packets: %0d",
             checks, errs, pass_cnt, drop_cnt);
    if (errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/filter_engine_top.sv
/*
 * Filter engine top level
 * Configuration registers, condition kernel and stream stage.
 */

`timescale 1ns/1ns

module filter_engine_top import filter_pkg::*; #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                          ap_clk,
  input  logic                          rst_n,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0]         awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [31:0]                   wdata,
  input  logic [3:0]                    wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [AXI_ADDR_W-1:0]         araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Packet stream
  input  logic                          in_valid,
  input  logic [NUM_FIELDS*FIELD_W-1:0] in_data,
  input  logic [NUM_FIELDS*STATE_W-1:0] in_state,
  output logic                          out_valid,
  output logic [NUM_FIELDS*FIELD_W-1:0] out_data,
  output logic [NUM_FIELDS*STATE_W-1:0] out_state
);

  filter_op_t                       op;
  logic                             equal_flag;
  logic                             const_keep;
  logic [NUM_FIELDS-1:0]            filter_mask;
  logic [NUM_FIELDS-1:0]            const_mask;
  logic [FIELD_W-1:0]               const_value;
  logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask;
  logic                             res_pass;
  logic [31:0]                      pass_count;
  logic [31:0]                      drop_count;

  filter_config_regs #(
    .NUM_FIELDS (NUM_FIELDS)
  ) filter_config_regs_i (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .pass_count  (pass_count),
    .drop_count  (drop_count),
    .op          (op),
    .equal_flag  (equal_flag),
    .const_keep  (const_keep),
    .filter_mask (filter_mask),
    .const_mask  (const_mask),
    .const_value (const_value),
    .ops_mask    (ops_mask)
  );

  // Result fields go straight to the outputs
  filter_cond_kernel #(
    .NUM_FIELDS (NUM_FIELDS)
  ) filter_cond_kernel_i (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .op          (op),
    .equal_flag  (equal_flag),
    .const_keep  (const_keep),
    .filter_mask (filter_mask),
    .const_mask  (const_mask),
    .const_value (const_value),
    .ops_mask    (ops_mask),
    .in_data     (in_data),
    .in_state    (in_state),
    .res_data    (out_data),
    .res_state   (out_state),
    .res_pass    (res_pass)
  );

  filter_stream_stage #(
    .NUM_FIELDS (NUM_FIELDS)
  ) filter_stream_stage_i (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .res_pass   (res_pass),
    .out_valid  (out_valid),
    .pass_count (pass_count),
    .drop_count (drop_count)
  );

endmodule

// File: hdl/filter_stream_stage.sv
/*
 * Filter stream stage
 * Delays packet valid across the kernel pipeline, gates it with the
 * pass flag and counts passed and dropped packets.
 */

`timescale 1ns/1ns

module filter_stream_stage #(
  parameter int NUM_FIELDS = 4
) (
  input  logic        ap_clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic        res_pass,
  output logic        out_valid,
  output logic [31:0] pass_count,
  output logic [31:0] drop_count
);

  // One bit per kernel stage
  logic [2:0] vld_q;

  if (NUM_FIELDS < 2 || NUM_FIELDS > 8) begin : g_bad_num_fields
    $error("NUM_FIELDS must lie between 2 and 8");
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) vld_q <= '0;
    else        vld_q <= {vld_q[1:0], in_valid};
  end

  assign out_valid = vld_q[2] & res_pass;

  // --------------------
  // Packet counters
  // --------------------
  // Both wrap at 2^32
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_count <= '0;
      drop_count <= '0;
    end else if (vld_q[2]) begin
      if (res_pass) pass_count <= pass_count + 32'd1;
      else          drop_count <= drop_count + 32'd1;
    end
  end

  // Output only for a packet sent exactly one kernel latency ago
  a_out_needs_in: assert property (@(posedge ap_clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, 3));

endmodule

// File: hdl/filter_cond_kernel.sv
/*
 * Filter condition kernel
 * Three-stage pipeline: operand routing, opcode evaluation and
 * reduction of the per-field conditions into a pass flag.
 */

`timescale 1ns/1ns

module filter_cond_kernel import filter_pkg::*; #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                             ap_clk,
  input  logic                             rst_n,
  input  filter_op_t                       op,
  input  logic                             equal_flag,
  input  logic                             const_keep,
  input  logic [NUM_FIELDS-1:0]            filter_mask,
  input  logic [NUM_FIELDS-1:0]            const_mask,
  input  logic [FIELD_W-1:0]               const_value,
  input  logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask,
  input  logic [NUM_FIELDS*FIELD_W-1:0]    in_data,
  input  logic [NUM_FIELDS*STATE_W-1:0]    in_state,
  output logic [NUM_FIELDS*FIELD_W-1:0]    res_data,
  output logic [NUM_FIELDS*STATE_W-1:0]    res_state,
  output logic                             res_pass
);

  // Routed input per field, before the constant is applied
  logic [FIELD_W-1:0]    route_data  [NUM_FIELDS];
  field_state_t          route_state [NUM_FIELDS];

  // Stage 1
  logic [FIELD_W-1:0]    ops_s1      [NUM_FIELDS];
  field_state_t          ops_st_s1   [NUM_FIELDS];
  logic [FIELD_W-1:0]    org_s1      [NUM_FIELDS];
  field_state_t          org_st_s1   [NUM_FIELDS];
  filter_op_t            op_s1;
  logic                  eq_s1;
  logic [NUM_FIELDS-1:0] mask_s1;

  // Stage 2
  logic [FIELD_W-1:0]    res_d       [NUM_FIELDS];
  field_state_t          res_st_d    [NUM_FIELDS];
  logic [NUM_FIELDS-1:0] cond_d;
  logic                  tern_hold;
  logic [FIELD_W-1:0]    res_s2      [NUM_FIELDS];
  field_state_t          res_st_s2   [NUM_FIELDS];
  logic [NUM_FIELDS-1:0] cond_s2;
  logic [NUM_FIELDS-1:0] mask_s2;

  // Unsigned compare shared by plain and ternary ops
  function automatic logic cmp_hold(input filter_op_t        o,
                                    input logic [FIELD_W-1:0] a,
                                    input logic [FIELD_W-1:0] b,
                                    input logic               eq_flag);
    case (o)
      FILTER_GT, FILTER_GT_TERN:         return (a > b) || (eq_flag && a == b);
      FILTER_LT, FILTER_LT_TERN:         return (a < b) || (eq_flag && a == b);
      FILTER_EQ, FILTER_EQ_TERN:         return a == b;
      FILTER_NOT_EQ, FILTER_NOT_EQ_TERN: return a != b;
      default:                           return 1'b1;
    endcase
  endfunction

  // --------------------
  // Stage 1: operand routing
  // --------------------
  // Highest set bit of the ops mask wins
  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      route_data[i]  = '0;
      route_state[i] = FIELD_INVALID;
      for (int j = 0; j < NUM_FIELDS; j++) begin
        if (ops_mask[i*NUM_FIELDS + j]) begin
          route_data[i]  = in_data[j*FIELD_W +: FIELD_W];
          route_state[i] = field_state_t'(in_state[j*STATE_W +: STATE_W]);
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (const_mask[i]) begin
        ops_s1[i]    <= const_value;
        ops_st_s1[i] <= FIELD_RUNNING;
      end else begin
        ops_s1[i]    <= route_data[i];
        ops_st_s1[i] <= route_state[i];
      end
      // Original value sees the constant only when it is kept
      if (const_mask[i] && const_keep) begin
        org_s1[i]    <= const_value;
        org_st_s1[i] <= FIELD_RUNNING;
      end else begin
        org_s1[i]    <= route_data[i];
        org_st_s1[i] <= route_state[i];
      end
    end
    eq_s1   <= equal_flag;
    mask_s1 <= filter_mask;
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) op_s1 <= FILTER_NOP;
    else        op_s1 <= op;
  end

  // --------------------
  // Stage 2: opcode evaluation
  // --------------------
  always_comb begin
    tern_hold = cmp_hold(op_s1, ops_s1[0], ops_s1[1], eq_s1);
    cond_d    = '1;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      res_d[i]    = org_s1[i];
      res_st_d[i] = org_st_s1[i];
    end
    case (op_s1)
      FILTER_NOP: begin
        res_d    = ops_s1;
        res_st_d = ops_st_s1;
      end
      FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NOT_EQ: begin
        // Each field against its right neighbour, wrapping at the end
        for (int i = 0; i < NUM_FIELDS; i++) begin
          cond_d[i] = cmp_hold(op_s1, ops_s1[i], ops_s1[(i + 1) % NUM_FIELDS], eq_s1);
        end
      end
      FILTER_GT_TERN, FILTER_LT_TERN: begin
        res_d = ops_s1;
        if (!tern_hold) begin
          res_d[0] = ops_s1[1];
          res_d[1] = ops_s1[0];
        end
      end
      FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        res_d = ops_s1;
        if (tern_hold) begin
          res_d[0]            = ops_s1[NUM_FIELDS-1];
          res_d[NUM_FIELDS-1] = ops_s1[0];
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    res_s2    <= res_d;
    res_st_s2 <= res_st_d;
    cond_s2   <= cond_d;
    mask_s2   <= mask_s1;
  end

  // --------------------
  // Stage 3: pass reduction
  // --------------------
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      res_data[i*FIELD_W +: FIELD_W]  <= res_s2[i];
      res_state[i*STATE_W +: STATE_W] <= res_st_s2[i];
    end
    res_pass <= &(cond_s2 | ~mask_s2);
  end

  // Opcode from the register block is always a defined value
  a_op_known: assert property (@(posedge ap_clk) disable iff (!rst_n)
    !$isunknown(op_s1));

endmodule

// File: hdl/filter_config_regs.sv
/*
 * Filter configuration registers
 * AXI4-Lite slave, one transaction of each kind at a time. Holds the
 * kernel configuration and reads back the pass and drop counters.
 */

`timescale 1ns/1ns

module filter_config_regs import filter_pkg::*; #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                             ap_clk,
  input  logic                             rst_n,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0]            awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [31:0]                      wdata,
  input  logic [3:0]                       wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  logic                             bready,
  input  logic [AXI_ADDR_W-1:0]            araddr,
  input  logic                             arvalid,
  output logic                             arready,
  output logic [31:0]                      rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  logic                             rready,
  // Counters from the stream stage
  input  logic [31:0]                      pass_count,
  input  logic [31:0]                      drop_count,
  // Kernel configuration
  output filter_op_t                       op,
  output logic                             equal_flag,
  output logic                             const_keep,
  output logic [NUM_FIELDS-1:0]            filter_mask,
  output logic [NUM_FIELDS-1:0]            const_mask,
  output logic [FIELD_W-1:0]               const_value,
  output logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask
);

  logic                  wr_en;
  logic                  rd_en;
  logic [31:0]           rd_mux;
  logic [NUM_FIELDS-1:0] ops_mask_q [NUM_FIELDS];

  function automatic logic [AXI_ADDR_W-1:0] ops_addr(input int idx);
    return AXI_ADDR_W'(REG_OPS_BASE + 4 * idx);
  endfunction

  // Byte-wise merge for the full width register
  function automatic logic [31:0] strb_merge(input logic [31:0] cur,
                                             input logic [31:0] data,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    merged = cur;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
  endfunction

  // Address and data are taken together, held back by a pending response
  assign wr_en   = awvalid & wvalid & ~bvalid;
  assign awready = wr_en;
  assign wready  = wr_en;
  assign rd_en   = arvalid & ~rvalid;
  assign arready = rd_en;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // --------------------
  // Write path
  // --------------------
  // Registers narrower than 9 bits live entirely in byte lane 0
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      op          <= FILTER_NOP;
      equal_flag  <= 1'b0;
      const_keep  <= 1'b0;
      filter_mask <= '0;
      const_mask  <= '0;
      const_value <= '0;
      ops_mask_q  <= '{default: '0};
      bvalid      <= 1'b0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_en) begin
        bvalid <= 1'b1;
        case (awaddr)
          REG_CTRL: begin
            if (wstrb[0]) begin
              op         <= filter_op_t'(wdata[3:0]);
              equal_flag <= wdata[4];
              const_keep <= wdata[5];
            end
          end
          REG_FILTER_MASK: if (wstrb[0]) filter_mask <= wdata[NUM_FIELDS-1:0];
          REG_CONST_MASK:  if (wstrb[0]) const_mask <= wdata[NUM_FIELDS-1:0];
          REG_CONST_VALUE: const_value <= strb_merge(const_value, wdata, wstrb);
          default: begin
            for (int i = 0; i < NUM_FIELDS; i++) begin
              if (awaddr == ops_addr(i) && wstrb[0]) ops_mask_q[i] <= wdata[NUM_FIELDS-1:0];
            end
          end
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      ops_mask[i*NUM_FIELDS +: NUM_FIELDS] = ops_mask_q[i];
    end
  end

  // --------------------
  // Read path
  // --------------------
  always_comb begin
    rd_mux = '0;
    case (araddr)
      REG_CTRL:        rd_mux = {26'd0, const_keep, equal_flag, op};
      REG_FILTER_MASK: rd_mux = 32'(filter_mask);
      REG_CONST_MASK:  rd_mux = 32'(const_mask);
      REG_CONST_VALUE: rd_mux = const_value;
      REG_PASS_COUNT:  rd_mux = pass_count;
      REG_DROP_COUNT:  rd_mux = drop_count;
      default: begin
        // Unmapped addresses fall through as zero
        for (int i = 0; i < NUM_FIELDS; i++) begin
          if (araddr == ops_addr(i)) rd_mux = 32'(ops_mask_q[i]);
        end
      end
    endcase
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_en) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rd_en) rdata <= rd_mux;
  end

  // Write response held until the master takes it
  a_bvalid_hold: assert property (@(posedge ap_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);

endmodule

// File: hdl/filter_pkg.sv
/*
 * Filter engine package
 * Field widths, field sequence states, filter opcodes and the
 * AXI4-Lite register map of the configuration block.
 */

package filter_pkg;

  // --------------------
  // Packet field geometry
  // --------------------
  localparam int FIELD_W = 32;
  localparam int STATE_W = 2;

  // Sequence state carried with every field
  typedef enum logic [STATE_W-1:0] {
    FIELD_INVALID = 2'd0,
    FIELD_RUNNING = 2'd1,
    FIELD_DONE    = 2'd2
  } field_state_t;

  // Filter opcodes, codes 9 to 15 are undefined
  typedef enum logic [3:0] {
    FILTER_NOP         = 4'd0,
    FILTER_GT          = 4'd1,
    FILTER_LT          = 4'd2,
    FILTER_EQ          = 4'd3,
    FILTER_NOT_EQ      = 4'd4,
    FILTER_GT_TERN     = 4'd5,
    FILTER_LT_TERN     = 4'd6,
    FILTER_EQ_TERN     = 4'd7,
    FILTER_NOT_EQ_TERN = 4'd8
  } filter_op_t;

  // --------------------
  // Register map
  // --------------------
  localparam int AXI_ADDR_W = 6;

  // CTRL layout is opcode in 3:0, equal_flag in 4, const_keep in 5
  localparam logic [AXI_ADDR_W-1:0] REG_CTRL        = 6'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_FILTER_MASK = 6'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_CONST_MASK  = 6'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_CONST_VALUE = 6'h0C;
  // Read only counters
  localparam logic [AXI_ADDR_W-1:0] REG_PASS_COUNT  = 6'h10;
  localparam logic [AXI_ADDR_W-1:0] REG_DROP_COUNT  = 6'h14;
  // Ops mask of field i sits at REG_OPS_BASE + 4*i
  localparam logic [AXI_ADDR_W-1:0] REG_OPS_BASE    = 6'h20;

endpackage
